//--- sources.f
hdl/mcu_isa_pkg.sv
hdl/mcu_map_pkg.sv
hdl/mcu_bus_if.sv
hdl/mcu_cpu.sv
hdl/mcu_rom.sv
hdl/mcu_ram.sv
hdl/mcu_periph.sv
hdl/mcu_top.sv
verif/mcu_chk.sv
verif/mcu_monitor.sv
verif/mcu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mcu_tb -f sources.f -o mcu_sim

./obj_dir/mcu_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi

//--- verif/mcu_tb.sv
`timescale 1ns/1ps

module mcu_tb;
    import mcu_map_pkg::*;

    localparam int n_entries = 10;
    // four program loops of about 100 cycles per entry, plus timer slack
    localparam int watchdog_cycles = n_entries * 4 * 100 + 4 * int'(tmr_prescale);

    logic        clk;
    logic        rst;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic        debug;
    logic        quit;
    logic        go;
    logic [1:0]  mode;
    logic [7:0]  exp;
    int          idx;
    logic        done;
    int          n_pass;
    int          n_fail;
    int          n_err;

    // mode 0 is key xor on gpo low, 1 halt, 2 frozen after halt and 3 timer and debug
    logic [1:0]  tbl_mode [n_entries];
    logic [15:0] tbl_gpi [n_entries];
    logic [7:0]  tbl_exp [n_entries];

    mcu_top DUT (
        .clk(clk),
        .rst(rst),
        .gpi(gpi),
        .gpo(gpo),
        .debug(debug),
        .quit(quit)
    );

    mcu_monitor mon (
        .clk(clk),
        .rst(rst),
        .gpo(gpo),
        .debug(debug),
        .quit(quit),
        .go(go),
        .mode(mode),
        .exp(exp),
        .idx(idx),
        .done(done),
        .n_pass(n_pass),
        .n_fail(n_fail),
        .n_err(n_err)
    );

    bind mcu_cpu mcu_chk chk (
        .clk(clk),
        .rst(rst),
        .state(state),
        .addr(bus.addr),
        .write_en(bus.write_en),
        .debug(debug),
        .quit(quit)
    );

    task automatic set_entry(input int i, input logic [1:0] m, input logic [15:0] g);
        tbl_mode[i] = m;
        tbl_gpi[i]  = g;
        // program key is 0x5a
        case (m)
            2'd0:    tbl_exp[i] = g[7:0] ^ 8'h5a;
            2'd1:    tbl_exp[i] = 8'h01;
            default: tbl_exp[i] = 8'h00;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * 4);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'ha721));
        rst  = 1'b1;
        gpi  = 16'h0000;
        go   = 1'b0;
        mode = 2'd0;
        exp  = 8'h00;
        idx  = 0;
        set_entry(0, 2'd3, 16'h0000);
        set_entry(1, 2'd0, 16'h0000);
        set_entry(2, 2'd0, 16'h00ff);
        set_entry(3, 2'd0, 16'h7f5a);
        set_entry(4, 2'd0, 16'($urandom) & 16'h7fff);
        set_entry(5, 2'd0, 16'($urandom) & 16'h7fff);
        set_entry(6, 2'd0, 16'($urandom) & 16'h7fff);
        set_entry(7, 2'd0, 16'h00a5);
        set_entry(8, 2'd1, 16'h8000);
        set_entry(9, 2'd2, 16'($urandom));
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            @(negedge clk);
            gpi  = tbl_gpi[i];
            mode = tbl_mode[i];
            exp  = tbl_exp[i];
            idx  = i;
            go   = 1'b1;
            @(negedge clk);
            go = 1'b0;
            while (!done) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        $display("tests: %0d passed, %0d failed, %0d other errors", n_pass, n_fail, n_err);
        if (n_fail == 0 && n_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verif/mcu_monitor.sv
`timescale 1ns/1ps

module mcu_monitor (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] gpo,
    input  logic        debug,
    input  logic        quit,
    input  logic        go,
    input  logic [1:0]  mode,
    input  logic [7:0]  exp,
    input  int          idx,
    output logic        done,
    output int          n_pass,
    output int          n_fail,
    output int          n_err
);
    import mcu_map_pkg::*;

    // per-test limits in clock cycles
    localparam int loop_lim = 400;
    localparam int tick_lim = 3 * int'(tmr_prescale);

    logic        busy;
    logic [1:0]  cur_mode;
    logic [7:0]  cur_exp;
    int          cur_idx;
    int          cyc;
    int          ticks;
    int          pulses;
    int          since_hi;
    int          err_snap;
    logic        rst_q;
    logic        debug_q;
    logic        quit_q;
    logic [15:0] gpo_q;

    task automatic end_test(input logic ok, input string msg);
        if (ok) begin
            n_pass++;
            $display("test %0d ok: %s", cur_idx, msg);
        end else begin
            n_fail++;
        end
        busy = 1'b0;
        done = 1'b1;
    endtask

    always @(posedge clk) begin
        done = 1'b0;
        if (rst) begin
            busy     = 1'b0;
            n_pass   = 0;
            n_fail   = 0;
            n_err    = 0;
            since_hi = 0;
            debug_q  = 1'b0;
            quit_q   = 1'b0;
            gpo_q    = 16'h0000;
        end else begin
            // first cycle out of reset
            if (rst_q) begin
                if (gpo !== 16'h0000 || quit !== 1'b0 || debug !== 1'b0) begin
                    $display("Fail t=%0t gpo/quit/debug expected 0000/0/0 got %04h/%b/%b",
                             $time, gpo, quit, debug);
                    n_fail++;
                end else begin
                    n_pass++;
                    $display("test reset ok: gpo clear, quit and debug low");
                end
            end
            // tick counter on gpo[15:8] only ever steps by one
            if (gpo[15:8] != gpo_q[15:8]) begin
                if (gpo[15:8] != gpo_q[15:8] + 8'd1) begin
                    $display("Fail t=%0t gpo[15:8] expected %02h got %02h",
                             $time, gpo_q[15:8] + 8'd1, gpo[15:8]);
                    n_err++;
                end
                ticks++;
                since_hi = 0;
            end else if (!quit) begin
                since_hi++;
                if (since_hi > tick_lim) begin
                    $display("error at %0t: gpo[15:8] did not advance within %0d cycles",
                             $time, tick_lim);
                    n_err++;
                    since_hi = 0;
                end
            end
            if (debug && !debug_q) begin
                pulses++;
            end
            if (debug && debug_q) begin
                $display("error at %0t: debug high for more than one cycle", $time);
                n_err++;
            end
            // after halt nothing may move
            if (quit_q && !quit) begin
                $display("error at %0t: quit dropped after halt", $time);
                n_err++;
            end
            if (quit_q && gpo !== gpo_q) begin
                $display("Fail t=%0t gpo expected %04h got %04h", $time, gpo_q, gpo);
                n_err++;
            end
            if (quit_q && debug) begin
                $display("error at %0t: debug pulsed after halt", $time);
                n_err++;
            end
            if (busy) begin
                cyc++;
                case (cur_mode)
                    // gpo low byte follows gpi low byte through the key
                    2'd0: begin
                        if (gpo[7:0] == cur_exp) begin
                            end_test(1'b1, "gpo[7:0] matches gpi[7:0] ^ key");
                        end else if (cyc >= loop_lim) begin
                            $display("Fail t=%0t gpo[7:0] expected %02h got %02h",
                                     $time, cur_exp, gpo[7:0]);
                            end_test(1'b0, "");
                        end
                    end
                    2'd1: begin
                        if (quit) begin
                            end_test(1'b1, "quit raised by gpi[15]");
                        end else if (cyc >= loop_lim) begin
                            $display("Fail t=%0t quit expected 1 got 0", $time);
                            end_test(1'b0, "");
                        end
                    end
                    2'd2: begin
                        if (cyc >= loop_lim) begin
                            if (n_err != err_snap) begin
                                $display("test %0d failed: outputs moved after halt", cur_idx);
                            end
                            end_test(n_err == err_snap, "gpo and debug frozen after halt");
                        end
                    end
                    default: begin
                        if (ticks > 0 && pulses > 1) begin
                            end_test(1'b1, "timer count and debug pulses seen");
                        end else if (cyc >= tick_lim) begin
                            $display("test %0d failed: no timer count or debug pulses in %0d cycles",
                                     cur_idx, tick_lim);
                            end_test(1'b0, "");
                        end
                    end
                endcase
            end
            if (go) begin
                busy     = 1'b1;
                cur_mode = mode;
                cur_exp  = exp;
                cur_idx  = idx;
                cyc      = 0;
                ticks    = 0;
                pulses   = 0;
                err_snap = n_err;
            end
            debug_q = debug;
            quit_q  = quit;
            gpo_q   = gpo;
        end
        rst_q = rst;
    end

endmodule

//--- verif/mcu_chk.sv
`timescale 1ns/1ps

module mcu_chk (
    input logic                           clk,
    input logic                           rst,
    input mcu_isa_pkg::cpu_state_t        state,
    input logic [mcu_isa_pkg::addr_w-1:0] addr,
    input logic                           write_en,
    input logic                           debug,
    input logic                           quit
);
    import mcu_isa_pkg::*;
    import mcu_map_pkg::*;

    // fetches never store and stay inside the ROM
    a_no_fetch_write: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_fetch_op || state == st_fetch_arg) |-> (!write_en && addr < ram_base)
    ) else $error("write_en high or address outside ROM during instruction fetch");

    // halt is final until reset
    a_quit_sticky: assert property (@(posedge clk) disable iff (rst) quit |=> quit)
        else $error("quit fell while rst was low");

    a_debug_pulse: assert property (@(posedge clk) disable iff (rst) debug |=> !debug)
        else $error("debug held high for more than one cycle");

endmodule

//--- hdl/mcu_top.sv
`timescale 1ns/1ps

module mcu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] gpi,
    output logic [15:0] gpo,
    output logic        debug,
    output logic        quit
);

    // shared bus, read data is ORed inside the interface
    mcu_bus_if bus (
        .clk(clk)
    );

    mcu_cpu cpu (
        .clk(clk),
        .rst(rst),
        .bus(bus.cpu),
        .debug(debug),
        .quit(quit)
    );

    // 0x00 to 0x7f, program
    mcu_rom mem_inst (
        .clk(clk),
        .bus(bus.slave)
    );

    // 0x80 to 0xed, data
    mcu_ram mem_data (
        .clk(clk),
        .rst(rst),
        .bus(bus.slave)
    );

    // 0xee to 0xff, gpio and timer
    mcu_periph periph (
        .clk(clk),
        .rst(rst),
        .bus(bus.slave),
        .gpi(gpi),
        .gpo(gpo)
    );

endmodule

//--- hdl/mcu_periph.sv
`timescale 1ns/1ps

module mcu_periph (
    input  logic        clk,
    input  logic        rst,
    mcu_bus_if.slave    bus,
    input  logic [15:0] gpi,
    output logic [15:0] gpo
);
    import mcu_isa_pkg::*;
    import mcu_map_pkg::*;

    logic              sel;
    logic [word_w-1:0] rd_mux;
    logic [15:0]       presc;
    logic              tick;
    logic              tmr_flag;
    logic              flag_clr;

    assign sel = (bus.addr >= periph_base);

    always_comb begin
        case (bus.addr)
            reg_gpi_lo:   rd_mux = gpi[7:0];
            reg_gpi_hi:   rd_mux = gpi[15:8];
            reg_gpo_lo:   rd_mux = gpo[7:0];
            reg_gpo_hi:   rd_mux = gpo[15:8];
            reg_tmr_flag: rd_mux = {7'b0, tmr_flag};
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.per_rdata <= '0;
        end else begin
            bus.per_rdata <= sel ? rd_mux : '0;
        end
    end

    // gpo bytes only change on a CPU write
    always_ff @(posedge clk) begin
        if (rst) begin
            gpo <= '0;
        end else if (bus.write_en && sel) begin
            case (bus.addr)
                reg_gpo_lo: gpo[7:0]  <= bus.wdata;
                reg_gpo_hi: gpo[15:8] <= bus.wdata;
                default:    gpo       <= gpo;
            endcase
        end
    end

    // prescaler wraps every tmr_prescale cycles
    assign tick = (presc == tmr_prescale - 16'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
        end else begin
            presc <= tick ? '0 : presc + 16'd1;
        end
    end

    assign flag_clr = bus.write_en && (bus.addr == reg_tmr_flag);

    // sticky flag, a new tick wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            tmr_flag <= 1'b0;
        end else if (tick) begin
            tmr_flag <= 1'b1;
        end else if (flag_clr) begin
            tmr_flag <= 1'b0;
        end
    end

endmodule

//--- hdl/mcu_ram.sv
`timescale 1ns/1ps

module mcu_ram (
    input logic      clk,
    input logic      rst,
    mcu_bus_if.slave bus
);
    import mcu_isa_pkg::*;
    import mcu_map_pkg::*;

    logic [word_w-1:0] mem [periph_base - ram_base];
    logic [addr_w-1:0] offs;
    logic              sel;

    // window ends where the peripherals start
    assign sel  = (bus.addr >= ram_base) && (bus.addr < periph_base);
    assign offs = bus.addr - ram_base;

    always_ff @(posedge clk) begin
        if (sel && bus.write_en) begin
            mem[offs[6:0]] <= bus.wdata;
        end
    end

    // registered read, zero when another block is addressed
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ram_rdata <= '0;
        end else if (sel) begin
            bus.ram_rdata <= mem[offs[6:0]];
        end else begin
            bus.ram_rdata <= '0;
        end
    end

endmodule

//--- hdl/mcu_rom.sv
`timescale 1ns/1ps

module mcu_rom (
    input logic      clk,
    mcu_bus_if.slave bus
);
    import mcu_isa_pkg::*;
    import mcu_map_pkg::*;

    // fixed program, two bytes per instruction
    function automatic logic [word_w-1:0] rom_byte(input logic [6:0] a);
        case (a)
            // key and counter setup
            7'h00: rom_byte = op_ldi;
            7'h01: rom_byte = 8'h5a;
            7'h02: rom_byte = op_sta;
            7'h03: rom_byte = key_addr;
            7'h04: rom_byte = op_ldi;
            7'h05: rom_byte = 8'h00;
            7'h06: rom_byte = op_sta;
            7'h07: rom_byte = cnt_addr;
            // main loop at 0x08, gpo low = gpi low ^ key
            7'h08: rom_byte = op_lda;
            7'h09: rom_byte = key_addr;
            7'h0a: rom_byte = op_xor;
            7'h0b: rom_byte = reg_gpi_lo;
            7'h0c: rom_byte = op_sta;
            7'h0d: rom_byte = reg_gpo_lo;
            // poll timer, skip to 0x1c when no tick
            7'h0e: rom_byte = op_lda;
            7'h0f: rom_byte = reg_tmr_flag;
            7'h10: rom_byte = op_jz;
            7'h11: rom_byte = 8'h1c;
            7'h12: rom_byte = op_sta;
            7'h13: rom_byte = reg_tmr_flag;
            7'h14: rom_byte = op_lda;
            7'h15: rom_byte = cnt_addr;
            7'h16: rom_byte = op_add;
            7'h17: rom_byte = 8'h7f;
            7'h18: rom_byte = op_sta;
            7'h19: rom_byte = cnt_addr;
            7'h1a: rom_byte = op_sta;
            7'h1b: rom_byte = reg_gpo_hi;
            7'h1c: rom_byte = op_dbg;
            // halt request on gpi[15]
            7'h1e: rom_byte = op_lda;
            7'h1f: rom_byte = reg_gpi_hi;
            7'h20: rom_byte = op_and;
            7'h21: rom_byte = 8'h7e;
            7'h22: rom_byte = op_jz;
            7'h23: rom_byte = 8'h08;
            7'h24: rom_byte = op_halt;
            // constant pool
            7'h7e: rom_byte = 8'h80;
            7'h7f: rom_byte = 8'h01;
            default: rom_byte = '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        bus.rom_rdata <= bus.addr[7] ? '0 : rom_byte(bus.addr[6:0]);
    end

endmodule

//--- hdl/mcu_cpu.sv
`timescale 1ns/1ps

module mcu_cpu (
    input  logic   clk,
    input  logic   rst,
    mcu_bus_if.cpu bus,
    output logic   debug,
    output logic   quit
);
    import mcu_isa_pkg::*;

    cpu_state_t        state;
    opcode_t           ir;
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] pc_step;
    logic [addr_w-1:0] arg_q;
    logic [word_w-1:0] acc;

    assign pc_step = pc + addr_w'(2);

    // address mux, data for the address arrives one cycle later
    always_comb begin
        case (state)
            st_fetch_arg: bus.addr = pc + addr_w'(1);
            // argument byte is on rdata, use it as operand address
            st_exec:      bus.addr = bus.rdata;
            st_mem:       bus.addr = arg_q;
            default:      bus.addr = pc;
        endcase
    end

    assign bus.wdata    = acc;
    assign bus.write_en = (state == st_mem) && (ir == op_sta);

    assign debug = (state == st_exec) && (ir == op_dbg);
    assign quit  = (state == st_halt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch_op;
            ir    <= op_ldi;
            pc    <= '0;
            arg_q <= '0;
            acc   <= '0;
        end else begin
            case (state)
                st_fetch_op: begin
                    state <= st_fetch_arg;
                end
                st_fetch_arg: begin
                    // opcode byte from the fetch_op address
                    ir    <= opcode_t'(bus.rdata);
                    state <= st_exec;
                end
                st_exec: begin
                    arg_q <= bus.rdata;
                    case (ir)
                        op_ldi: begin
                            acc   <= bus.rdata;
                            pc    <= pc_step;
                            state <= st_fetch_op;
                        end
                        op_jmp: begin
                            pc    <= bus.rdata;
                            state <= st_fetch_op;
                        end
                        op_jz: begin
                            pc    <= (acc == '0) ? bus.rdata : pc_step;
                            state <= st_fetch_op;
                        end
                        op_lda, op_sta, op_add, op_xor, op_and: begin
                            state <= st_mem;
                        end
                        op_halt: begin
                            state <= st_halt;
                        end
                        // op_dbg and unknown opcodes just move on
                        default: begin
                            pc    <= pc_step;
                            state <= st_fetch_op;
                        end
                    endcase
                end
                st_mem: begin
                    // store happens on this edge via write_en
                    case (ir)
                        op_lda:  acc <= bus.rdata;
                        op_add:  acc <= acc + bus.rdata;
                        op_xor:  acc <= acc ^ bus.rdata;
                        op_and:  acc <= acc & bus.rdata;
                        default: acc <= acc;
                    endcase
                    pc    <= pc_step;
                    state <= st_fetch_op;
                end
                st_halt: begin
                    state <= st_halt;
                end
                default: begin
                    state <= st_fetch_op;
                end
            endcase
        end
    end

endmodule

//--- hdl/mcu_bus_if.sv
`timescale 1ns/1ps

interface mcu_bus_if (
    input logic clk
);
    import mcu_isa_pkg::*;

    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
    logic              write_en;

    // each slave drives zero when it is not addressed
    logic [word_w-1:0] rom_rdata;
    logic [word_w-1:0] ram_rdata;
    logic [word_w-1:0] per_rdata;
    logic [word_w-1:0] rdata;

    assign rdata = rom_rdata | ram_rdata | per_rdata;

    modport cpu (
        input  clk,
        output addr,
        output wdata,
        output write_en,
        input  rdata
    );

    modport slave (
        input  clk,
        input  addr,
        input  wdata,
        input  write_en,
        output rom_rdata,
        output ram_rdata,
        output per_rdata
    );

endinterface

//--- hdl/mcu_map_pkg.sv
package mcu_map_pkg;

    // region bases, ROM sits below ram_base
    localparam logic [7:0] ram_base    = 8'h80;
    localparam logic [7:0] periph_base = 8'hee;

    // gpio registers
    localparam logic [7:0] reg_gpi_lo = 8'hf1;
    localparam logic [7:0] reg_gpi_hi = 8'hf2;
    localparam logic [7:0] reg_gpo_lo = 8'hf3;
    localparam logic [7:0] reg_gpo_hi = 8'hf4;

    // timer flag, a write clears it
    localparam logic [7:0] reg_tmr_flag = 8'hf9;

    // clock cycles per timer tick
    localparam logic [15:0] tmr_prescale = 16'd200;

    // RAM cells used by the program
    localparam logic [7:0] key_addr = 8'h80;
    localparam logic [7:0] cnt_addr = 8'h81;

endpackage

//--- hdl/mcu_isa_pkg.sv
package mcu_isa_pkg;

    // datapath and address widths
    localparam int word_w = 8;
    localparam int addr_w = 8;

    // every instruction is opcode byte then argument byte
    typedef enum logic [7:0] {
        op_ldi  = 8'h10,
        op_lda  = 8'h20,
        op_sta  = 8'h21,
        op_add  = 8'h30,
        op_xor  = 8'h31,
        op_and  = 8'h32,
        op_jmp  = 8'h40,
        op_jz   = 8'h41,
        op_dbg  = 8'h50,
        op_halt = 8'h5f
    } opcode_t;

    // st_mem only for loads, stores and ALU ops
    typedef enum logic [2:0] {
        st_fetch_op  = 3'd0,
        st_fetch_arg = 3'd1,
        st_exec      = 3'd2,
        st_mem       = 3'd3,
        st_halt      = 3'd4
    } cpu_state_t;

endpackage
